/* all.f */
design/hamming_pkg.sv
design/wb_codeword_port.sv
design/hamming_lane_decoder.sv
design/decode_status_collector.sv
design/hamming_wb_top.sv
dv/hamming_wb_checker.sv
dv/tb_hamming_wb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the Hamming Wishbone testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hamming_wb \
    -f all.f \
    -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failure"

/* dv/tb_hamming_wb.sv */
`timescale 1ns/10ps

module tb_hamming_wb
    import hamming_pkg::*;
();

    localparam int N_CLEAN       = 200;
    localparam int N_SINGLE      = 100;
    localparam int N_DOUBLE      = 100;
    localparam int N_LANE_ROUNDS = 50;
    localparam int N_AFTER_CLEAR = 20;
    // Bus transfers issued by all tests together
    localparam int N_XFERS = N_CLEAN * 3 + 2 + (N_SINGLE + N_DOUBLE) * 5
                           + N_LANE_ROUNDS * 7 + N_AFTER_CLEAR + 7;
    localparam int TIMEOUT_CYCLES = 4 * N_XFERS * 3 + 100;

    // Data positions, MSB first
    localparam int DATA_POS [DATA_W] = '{3, 5, 6, 7, 9, 10, 11, 12};

    logic      clk;
    logic      reset;
    wb_req_t   wb_req;
    logic      ack;
    bus_word_t dat_r;

    lane_result_t model_res [N_LANES];
    codeword_t    model_code [N_LANES];
    count_t       exp_corr;
    count_t       exp_unc;
    int           test_errors;
    int           total_errors;
    int           tests_ok;
    int           tests_bad;
    int           cycle_count;

    hamming_wb_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .ack    (ack),
        .dat_r  (dat_r)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles before all tests finished", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic syndrome_t syndrome_of(codeword_t cw);
        syndrome_t syn;
        syn = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (cw[CODE_W - p]) begin
                syn = syn ^ syndrome_t'(p);
            end
        end
        return syn;
    endfunction

    function automatic codeword_t flip_position(codeword_t cw, int pos);
        codeword_t res;
        res = cw;
        res[CODE_W - pos] = ~cw[CODE_W - pos];
        return res;
    endfunction

    function automatic codeword_t encode_byte(data_byte_t d);
        codeword_t cw;
        syndrome_t syn;
        cw = '0;
        for (int i = 0; i < DATA_W; i++) begin
            cw[CODE_W - DATA_POS[i]] = d[DATA_W - 1 - i];
        end
        // Parity at positions 1, 2, 4 and 8 cancels the syndrome
        syn = syndrome_of(cw);
        for (int b = 0; b < SYN_W; b++) begin
            cw[CODE_W - (1 << b)] = syn[b];
        end
        return cw;
    endfunction

    function automatic lane_result_t predict_lane(codeword_t cw);
        lane_result_t res;
        codeword_t    fixed;
        int           s;
        s = int'(syndrome_of(cw));
        fixed = cw;
        if (s >= 1 && s <= CODE_W) begin
            fixed = flip_position(cw, s);
        end
        for (int i = 0; i < DATA_W; i++) begin
            res.data[DATA_W - 1 - i] = fixed[CODE_W - DATA_POS[i]];
        end
        res.syndrome      = syndrome_t'(s);
        res.corrected     = (s >= 1 && s <= CODE_W);
        res.uncorrectable = (s > CODE_W);
        return res;
    endfunction

    function automatic count_t sat_inc(count_t c);
        return (c == '1) ? c : c + count_t'(1);
    endfunction

    function automatic bus_word_t expected_data_word();
        bus_word_t w;
        w = '0;
        for (int k = 0; k < N_LANES; k++) begin
            w[k*DATA_W +: DATA_W] = model_res[k].data;
        end
        return w;
    endfunction

    function automatic bus_word_t expected_flags_word();
        bus_word_t w;
        w = '0;
        for (int k = 0; k < N_LANES; k++) begin
            w[k]           = model_res[k].corrected;
            w[N_LANES + k] = model_res[k].uncorrectable;
        end
        return w;
    endfunction

    // ========================================================================
    // Bus tasks
    // ========================================================================
    task automatic wait_ack();
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
    endtask

    task automatic wb_write(input bus_adr_t adr, input bus_word_t data);
        @(posedge clk);
        #1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        wait_ack();
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_read(input bus_adr_t adr, output bus_word_t data);
        @(posedge clk);
        #1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = adr;
        wb_req.dat_w = '0;
        wait_ack();
        data = dat_r;
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic compare_word(input string name, input bus_word_t expected,
                                input bus_word_t actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%08h actual 0x%08h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_count(input string name, input count_t expected,
                                 input count_t actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%04h actual 0x%04h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("Check %s: ok", name);
            tests_ok++;
        end else begin
            $display("Check %s: %0d mismatches", name, test_errors);
            tests_bad++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    task automatic load_lane(input int k, input codeword_t cw);
        wb_write(ADR_CODE0 + bus_adr_t'(k), bus_word_t'(cw));
        model_code[k] = cw;
        model_res[k]  = predict_lane(cw);
        if (model_res[k].corrected) begin
            exp_corr = sat_inc(exp_corr);
        end
        if (model_res[k].uncorrectable) begin
            exp_unc = sat_inc(exp_unc);
        end
    endtask

    task automatic check_lanes();
        bus_word_t rd;
        wb_read(ADR_DATA, rd);
        compare_word("dat_r data", expected_data_word(), rd);
        wb_read(ADR_FLAGS, rd);
        compare_word("dat_r flags", expected_flags_word(), rd);
    endtask

    task automatic check_counters();
        bus_word_t rd;
        wb_read(ADR_CNT_CORR, rd);
        compare_count("cnt_corr", exp_corr, count_t'(rd));
        wb_read(ADR_CNT_UNC, rd);
        compare_count("cnt_unc", exp_unc, count_t'(rd));
    endtask

    function automatic codeword_t random_errors(codeword_t cw, int n_flips);
        int p1;
        int p2;
        codeword_t res;
        res = cw;
        p1 = $urandom_range(1, CODE_W);
        if (n_flips >= 1) begin
            res = flip_position(res, p1);
        end
        if (n_flips == 2) begin
            p2 = $urandom_range(1, CODE_W);
            while (p2 == p1) begin
                p2 = $urandom_range(1, CODE_W);
            end
            res = flip_position(res, p2);
        end
        return res;
    endfunction

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic run_flip_words(input int n_words, input int n_flips);
        codeword_t cw;
        for (int i = 0; i < n_words; i++) begin
            cw = encode_byte(data_byte_t'($urandom));
            load_lane($urandom_range(0, N_LANES - 1), random_errors(cw, n_flips));
            check_lanes();
            if (n_flips > 0) begin
                check_counters();
            end
        end
    endtask

    task automatic run_lane_readback();
        bus_word_t rd;
        for (int i = 0; i < N_LANE_ROUNDS; i++) begin
            load_lane($urandom_range(0, N_LANES - 1), codeword_t'($urandom));
            for (int j = 0; j < N_LANES; j++) begin
                wb_read(ADR_CODE0 + bus_adr_t'(j), rd);
                compare_word($sformatf("dat_r code%0d", j), bus_word_t'(model_code[j]), rd);
            end
            // Full compare also covers the lanes that were not written
            check_lanes();
        end
    endtask

    task automatic run_counter_clear();
        int n_flips;
        wb_write(ADR_CNT_CORR, bus_word_t'($urandom));
        exp_corr = '0;
        exp_unc  = '0;
        check_counters();
        for (int i = 0; i < N_AFTER_CLEAR; i++) begin
            n_flips = $urandom_range(1, 2);
            load_lane($urandom_range(0, N_LANES - 1),
                      random_errors(encode_byte(data_byte_t'($urandom)), n_flips));
        end
        check_lanes();
        check_counters();
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        wb_req       = '0;
        exp_corr     = '0;
        exp_unc      = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        cycle_count  = 0;
        for (int k = 0; k < N_LANES; k++) begin
            model_code[k] = '0;
            model_res[k]  = '0;
        end
        void'($urandom(31569));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        run_flip_words(N_CLEAN, 0);
        check_counters();
        finish_test("clean words");
        run_flip_words(N_SINGLE, 1);
        finish_test("single-bit errors");
        run_flip_words(N_DOUBLE, 2);
        finish_test("double errors");
        run_lane_readback();
        finish_test("codeword readback");
        run_counter_clear();
        finish_test("counter clear");

        $display("Summary: %0d checks ok, %0d checks with mismatches, %0d mismatches",
                 tests_ok, tests_bad, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dv/hamming_wb_checker.sv */
`timescale 1ns/10ps

module hamming_wb_checker
    import hamming_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  wb_req_t            wb_req,
    input  logic               ack,
    input  logic [N_LANES-1:0] load,
    input  logic [N_LANES-1:0] done
);

    // ========================================================================
    // Bus handshake
    // ========================================================================
    // Ack lasts one cycle per single transfer
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        ack |=> !ack
    ) else $error("ack stayed high for two cycles");

    ack_after_request: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("ack rose without a request");

    // ========================================================================
    // Lane load to done
    // ========================================================================
    for (genvar k = 0; k < N_LANES; k++) begin : g_lane_chk
        done_after_load: assert property (
            @(posedge clk) disable iff (reset)
            load[k] |=> done[k]
        ) else $error("lane %0d missed its done pulse", k);
    end

endmodule

bind hamming_wb_top hamming_wb_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .ack    (ack),
    .load   (load),
    .done   (done)
);

/* design/hamming_wb_top.sv */
`timescale 1ns/10ps

module hamming_wb_top
    import hamming_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  wb_req_t   wb_req,
    output logic      ack,
    output bus_word_t dat_r
);

    codeword_t          codewords [N_LANES];
    logic [N_LANES-1:0] load;
    lane_result_t       results [N_LANES];
    logic [N_LANES-1:0] done;
    logic               clear_counts;
    decode_status_t     status;

    // ========================================================================
    // Bus port
    // ========================================================================
    wb_codeword_port u_port (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .status       (status),
        .ack          (ack),
        .dat_r        (dat_r),
        .codewords    (codewords),
        .load         (load),
        .clear_counts (clear_counts)
    );

    // ========================================================================
    // Decoding lanes
    // ========================================================================
    for (genvar k = 0; k < N_LANES; k++) begin : g_lane
        hamming_lane_decoder u_lane (
            .clk      (clk),
            .reset    (reset),
            .codeword (codewords[k]),
            .load     (load[k]),
            .result   (results[k]),
            .done     (done[k])
        );
    end

    // Flags, bytes and counters for reads
    decode_status_collector u_collector (
        .clk          (clk),
        .reset        (reset),
        .results      (results),
        .done         (done),
        .clear_counts (clear_counts),
        .status       (status)
    );

endmodule

/* design/decode_status_collector.sv */
`timescale 1ns/10ps

module decode_status_collector
    import hamming_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  lane_result_t       results [N_LANES],
    input  logic [N_LANES-1:0] done,
    input  logic               clear_counts,
    output decode_status_t     status
);

    localparam int INC_W = $clog2(N_LANES + 1);

    logic [INC_W-1:0] n_corr;
    logic [INC_W-1:0] n_unc;
    count_t           cnt_corr;
    count_t           cnt_unc;

    function automatic count_t sat_add(input count_t cnt, input logic [INC_W-1:0] inc);
        logic [CNT_W:0] sum;
        sum = {1'b0, cnt} + inc;
        return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
    endfunction

    // Lane bytes and flags straight from the lane registers
    always_comb begin
        n_corr = '0;
        n_unc  = '0;
        for (int k = 0; k < N_LANES; k++) begin
            status.data_all[k*DATA_W +: DATA_W] = results[k].data;
            status.corrected_flags[k]           = results[k].corrected;
            status.uncorrectable_flags[k]       = results[k].uncorrectable;
            n_corr = n_corr + INC_W'(done[k] && results[k].corrected);
            n_unc  = n_unc + INC_W'(done[k] && results[k].uncorrectable);
        end
        status.cnt_corr = cnt_corr;
        status.cnt_unc  = cnt_unc;
    end

    // ========================================================================
    // Event counters, clear wins over counting
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset || clear_counts) begin
            cnt_corr <= '0;
            cnt_unc  <= '0;
        end else begin
            cnt_corr <= sat_add(cnt_corr, n_corr);
            cnt_unc  <= sat_add(cnt_unc, n_unc);
        end
    end

endmodule

/* design/hamming_lane_decoder.sv */
`timescale 1ns/10ps

module hamming_lane_decoder
    import hamming_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  codeword_t    codeword,
    input  logic         load,
    output lane_result_t result,
    output logic         done
);

    syndrome_t  syndrome;
    logic       fixable;
    logic       unfixable;
    codeword_t  fixed;
    data_byte_t data;

    // ========================================================================
    // Syndrome
    // ========================================================================
    // Bit 11 is position 1, bit 0 is position 12
    always_comb begin
        syndrome = '0;
        for (int i = 0; i < CODE_W; i++) begin
            if (codeword[i]) begin
                syndrome = syndrome ^ syndrome_t'(CODE_W - i);
            end
        end
    end

    assign fixable   = (syndrome != '0) && (syndrome <= syndrome_t'(CODE_W));
    assign unfixable = (syndrome > syndrome_t'(CODE_W));

    // ========================================================================
    // Single bit correction
    // ========================================================================
    always_comb begin
        fixed = codeword;
        if (fixable) begin
            fixed[CODE_W - int'(syndrome)] = ~codeword[CODE_W - int'(syndrome)];
        end
    end

    // Data at positions 3, 5, 6, 7, 9, 10, 11, 12, MSB first
    assign data = {fixed[9], fixed[7:5], fixed[3:0]};

    // ========================================================================
    // Result register
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (load) begin
            result.data          <= data;
            result.syndrome      <= syndrome;
            result.corrected     <= fixable;
            result.uncorrectable <= unfixable;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= load;
        end
    end

endmodule

/* design/wb_codeword_port.sv */
`timescale 1ns/10ps

module wb_codeword_port
    import hamming_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  wb_req_t        wb_req,
    input  decode_status_t status,
    output logic           ack,
    output bus_word_t      dat_r,
    output codeword_t      codewords [N_LANES],
    output logic [N_LANES-1:0] load,
    output logic           clear_counts
);

    logic bus_start;
    logic wr_en;

    // ========================================================================
    // Handshake
    // ========================================================================
    // New transfer only when ack is low, so ack lasts one cycle
    assign bus_start = wb_req.cyc && wb_req.stb && !ack;
    assign wr_en     = bus_start && wb_req.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= bus_start;
        end
    end

    // ========================================================================
    // Codeword registers and lane load pulses
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < N_LANES; k++) begin
                codewords[k] <= '0;
            end
        end else if (wr_en) begin
            for (int k = 0; k < N_LANES; k++) begin
                if (wb_req.adr == ADR_CODE0 + bus_adr_t'(k)) begin
                    codewords[k] <= wb_req.dat_w[CODE_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load         <= '0;
            clear_counts <= 1'b0;
        end else begin
            for (int k = 0; k < N_LANES; k++) begin
                load[k] <= wr_en && (wb_req.adr == ADR_CODE0 + bus_adr_t'(k));
            end
            clear_counts <= wr_en && (wb_req.adr == ADR_CNT_CORR);
        end
    end

    // ========================================================================
    // Read data
    // ========================================================================
    always_comb begin
        dat_r = '0;
        case (wb_req.adr)
            ADR_DATA: begin
                dat_r = bus_word_t'(status.data_all);
            end
            ADR_FLAGS: begin
                dat_r[N_LANES-1:0]         = status.corrected_flags;
                dat_r[2*N_LANES-1:N_LANES] = status.uncorrectable_flags;
            end
            ADR_CNT_CORR: begin
                dat_r = bus_word_t'(status.cnt_corr);
            end
            ADR_CNT_UNC: begin
                dat_r = bus_word_t'(status.cnt_unc);
            end
            default: begin
                // Stored codewords, upper bits stay zero
                for (int k = 0; k < N_LANES; k++) begin
                    if (wb_req.adr == ADR_CODE0 + bus_adr_t'(k)) begin
                        dat_r[CODE_W-1:0] = codewords[k];
                    end
                end
            end
        endcase
    end

endmodule

/* design/hamming_pkg.sv */
package hamming_pkg;

    // ========================================================================
    // Widths and lane count
    // ========================================================================
    localparam int N_LANES = 4;
    localparam int CODE_W  = 12;
    localparam int DATA_W  = 8;
    localparam int SYN_W   = 4;
    localparam int BUS_W   = 32;
    localparam int ADR_W   = 3;
    localparam int CNT_W   = 16;

    typedef logic [CODE_W-1:0] codeword_t;
    typedef logic [DATA_W-1:0] data_byte_t;
    typedef logic [SYN_W-1:0]  syndrome_t;
    typedef logic [CNT_W-1:0]  count_t;
    typedef logic [BUS_W-1:0]  bus_word_t;
    typedef logic [ADR_W-1:0]  bus_adr_t;

    // ========================================================================
    // Word address map
    // ========================================================================
    // Lanes 0 to 3 sit at ADR_CODE0 onwards
    localparam bus_adr_t ADR_CODE0    = 3'd0;
    localparam bus_adr_t ADR_DATA     = 3'd4;
    localparam bus_adr_t ADR_FLAGS    = 3'd5;
    localparam bus_adr_t ADR_CNT_CORR = 3'd6;
    localparam bus_adr_t ADR_CNT_UNC  = 3'd7;

    // ========================================================================
    // Bundled signals
    // ========================================================================
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_adr_t  adr;
        bus_word_t dat_w;
    } wb_req_t;

    typedef struct packed {
        data_byte_t data;
        syndrome_t  syndrome;
        logic       corrected;
        logic       uncorrectable;
    } lane_result_t;

    typedef struct packed {
        logic [N_LANES*DATA_W-1:0] data_all;
        logic [N_LANES-1:0]        corrected_flags;
        logic [N_LANES-1:0]        uncorrectable_flags;
        count_t                    cnt_corr;
        count_t                    cnt_unc;
    } decode_status_t;

endpackage
